/* mldsa_z_pkg.sv */
/*
 * Shared constants and types for the ML-DSA signature z decoder.
 * The RTL blocks and the testbench reference them by scoped name.
 */

package mldsa_z_pkg;

    // ========================================
    // Scheme sizes and bus widths
    // ========================================

    localparam int unsigned MLDSA_N        = 256;
    localparam int unsigned MLDSA_L        = 7;
    localparam int unsigned Z_ENC_WIDTH    = 20;
    localparam int unsigned COEF_WIDTH     = 24;
    localparam int unsigned MEM_ADDR_WIDTH = 15;

    // Four coefficients per memory word, two words per cycle
    localparam int unsigned Z_NUM_WORDS = (MLDSA_L * MLDSA_N) / 4;
    localparam int unsigned Z_NUM_PAIRS = Z_NUM_WORDS / 2;

    // One cycle of memory latency plus one cycle in the decode unit
    localparam int unsigned Z_PIPE_DELAY = 2;

    // Enough bits to count every read pair of a run
    localparam int unsigned Z_PAIR_CNT_WIDTH = $clog2(Z_NUM_PAIRS);

    // ========================================
    // Types
    // ========================================

    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;
    typedef logic [Z_ENC_WIDTH-1:0]      z_enc_t;
    typedef logic [COEF_WIDTH-1:0]       coef_t;
    typedef logic [4*Z_ENC_WIDTH-1:0]    z_enc_word_t;
    typedef logic [4*COEF_WIDTH-1:0]     coef_word_t;
    typedef logic [Z_PAIR_CNT_WIDTH-1:0] pair_cnt_t;

    typedef enum logic {
        Z_RD_IDLE,
        Z_RD_BUSY
    } z_rd_state_t;

    // ========================================
    // Values used by the decode arithmetic
    // ========================================

    // Modulus q
    localparam coef_t MLDSA_Q = 24'd8380417;

    // gamma1 is 2^19 and marks the centre of the encoded range
    localparam coef_t Z_GAMMA1 = 24'd524288;

    // Index of the final read pair in a run
    localparam pair_cnt_t Z_LAST_PAIR = pair_cnt_t'(Z_NUM_PAIRS - 1);

endpackage

/* sigdecode_z_rd_ctrl.sv */
/*
 * Read sequencer of the z decoder.
 * Accepts a start request while idle, locks the source base address and
 * issues one read on each of ports a and b per cycle for a full run.
 * Also tells the write side when a run starts and when reads are out.
 */

`timescale 1ns/1ps

module sigdecode_z_rd_ctrl (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic                   sigdecode_z_enable,
    input  mldsa_z_pkg::mem_addr_t sigmem_src_base_addr,
    output logic                   sig_a_rd_en,
    output logic                   sig_b_rd_en,
    output mldsa_z_pkg::mem_addr_t sig_a_rd_addr,
    output mldsa_z_pkg::mem_addr_t sig_b_rd_addr,
    output logic                   start,
    output logic                   rd_issue
);

    mldsa_z_pkg::z_rd_state_t state;
    mldsa_z_pkg::z_rd_state_t next_state;
    mldsa_z_pkg::pair_cnt_t   pair_cnt;
    mldsa_z_pkg::mem_addr_t   locked_src_addr;
    mldsa_z_pkg::mem_addr_t   pair_offset;
    logic                     rd_en_q;
    logic                     accept;
    logic                     last_pair;

    // ========================================
    // FSM
    // ========================================

    // A request that arrives during a run is simply dropped
    assign accept    = (state == mldsa_z_pkg::Z_RD_IDLE) && sigdecode_z_enable;
    assign last_pair = (pair_cnt == mldsa_z_pkg::Z_LAST_PAIR);

    always_comb begin
        next_state = state;
        case (state)
            mldsa_z_pkg::Z_RD_IDLE: begin
                if (sigdecode_z_enable) begin
                    next_state = mldsa_z_pkg::Z_RD_BUSY;
                end
            end
            mldsa_z_pkg::Z_RD_BUSY: begin
                if (last_pair) begin
                    next_state = mldsa_z_pkg::Z_RD_IDLE;
                end
            end
            default: begin
                next_state = mldsa_z_pkg::Z_RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= mldsa_z_pkg::Z_RD_IDLE;
        end else if (zeroize) begin
            state <= mldsa_z_pkg::Z_RD_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ========================================
    // Address lock, pair counter and strobes
    // ========================================

    // Port a takes the even word of each pair, port b the odd one
    assign pair_offset = mldsa_z_pkg::mem_addr_t'({pair_cnt, 1'b0});

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_src_addr <= '0;
            pair_cnt        <= '0;
            start           <= 1'b0;
            rd_en_q         <= 1'b0;
            sig_a_rd_addr   <= '0;
            sig_b_rd_addr   <= '0;
        end else if (zeroize) begin
            locked_src_addr <= '0;
            pair_cnt        <= '0;
            start           <= 1'b0;
            rd_en_q         <= 1'b0;
            sig_a_rd_addr   <= '0;
            sig_b_rd_addr   <= '0;
        end else begin
            start <= accept;
            if (accept) begin
                locked_src_addr <= sigmem_src_base_addr;
                pair_cnt        <= '0;
            end
            if (state == mldsa_z_pkg::Z_RD_BUSY) begin
                rd_en_q       <= 1'b1;
                sig_a_rd_addr <= locked_src_addr + pair_offset;
                sig_b_rd_addr <= locked_src_addr + pair_offset + 1'b1;
                pair_cnt      <= pair_cnt + 1'b1;
            end else begin
                rd_en_q       <= 1'b0;
                sig_a_rd_addr <= '0;
                sig_b_rd_addr <= '0;
            end
        end
    end

    // Both ports always read together
    assign sig_a_rd_en = rd_en_q;
    assign sig_b_rd_en = rd_en_q;
    assign rd_issue    = rd_en_q;

endmodule

/* sigdecode_z_unit.sv */
/*
 * One z coefficient decoder with a single register stage.
 * Maps an encoded value x to gamma1 - x, brought into the range 0..q-1.
 */

`timescale 1ns/1ps

module sigdecode_z_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  mldsa_z_pkg::z_enc_t enc,
    output mldsa_z_pkg::coef_t  coef
);

    // One extra bit on top of the coefficient width holds the sign
    logic [mldsa_z_pkg::COEF_WIDTH:0]   diff;
    logic [mldsa_z_pkg::COEF_WIDTH:0]   wrapped;
    mldsa_z_pkg::coef_t                 coef_next;

    // gamma1 - x lies in -(2^19 - 1) .. 2^19
    assign diff = {1'b0, mldsa_z_pkg::Z_GAMMA1} - {1'b0, mldsa_z_pkg::coef_t'(enc)};

    assign wrapped = diff + {1'b0, mldsa_z_pkg::MLDSA_Q};

    // A negative difference is lifted by q, anything else passes as is
    assign coef_next = diff[mldsa_z_pkg::COEF_WIDTH] ?
                       wrapped[mldsa_z_pkg::COEF_WIDTH-1:0] :
                       diff[mldsa_z_pkg::COEF_WIDTH-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coef <= '0;
        end else if (zeroize) begin
            coef <= '0;
        end else begin
            coef <= coef_next;
        end
    end

endmodule

/* sigdecode_z_wr_ctrl.sv */
/*
 * Write sequencer of the z decoder.
 * Locks the destination base at run start, delays the read strobe by the
 * memory plus decode latency, and turns it into paired write strobes and
 * addresses. Done pulses once after the last write of a run.
 */

`timescale 1ns/1ps

module sigdecode_z_wr_ctrl (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic                   start,
    input  logic                   rd_issue,
    input  mldsa_z_pkg::mem_addr_t dest_base_addr,
    output logic                   mem_a_wr_en,
    output logic                   mem_b_wr_en,
    output mldsa_z_pkg::mem_addr_t mem_a_wr_addr,
    output mldsa_z_pkg::mem_addr_t mem_b_wr_addr,
    output logic                   sigdecode_z_done
);

    // Stage i is high i+1 cycles after the matching read strobe
    logic [mldsa_z_pkg::Z_PIPE_DELAY-1:0] issue_pipe;
    mldsa_z_pkg::mem_addr_t               locked_dest_addr;
    mldsa_z_pkg::pair_cnt_t               pair_cnt;
    mldsa_z_pkg::mem_addr_t               pair_offset;
    logic                                 wr_next;
    logic                                 wr_now;

    // ========================================
    // Strobe pipeline
    // ========================================

    assign wr_next = issue_pipe[mldsa_z_pkg::Z_PIPE_DELAY-2];
    assign wr_now  = issue_pipe[mldsa_z_pkg::Z_PIPE_DELAY-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_pipe       <= '0;
            sigdecode_z_done <= 1'b0;
        end else if (zeroize) begin
            issue_pipe       <= '0;
            sigdecode_z_done <= 1'b0;
        end else begin
            issue_pipe[0] <= rd_issue;
            for (int i = 1; i < mldsa_z_pkg::Z_PIPE_DELAY; i++) begin
                issue_pipe[i] <= issue_pipe[i-1];
            end
            // Falling edge of the write strobe ends the run
            sigdecode_z_done <= wr_now && !wr_next;
        end
    end

    assign mem_a_wr_en = wr_now;
    assign mem_b_wr_en = wr_now;

    // ========================================
    // Destination addressing
    // ========================================

    assign pair_offset = mldsa_z_pkg::mem_addr_t'({pair_cnt, 1'b0});

    // Addresses are registered on the same edge that raises the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_dest_addr <= '0;
            pair_cnt         <= '0;
            mem_a_wr_addr    <= '0;
            mem_b_wr_addr    <= '0;
        end else if (zeroize) begin
            locked_dest_addr <= '0;
            pair_cnt         <= '0;
            mem_a_wr_addr    <= '0;
            mem_b_wr_addr    <= '0;
        end else begin
            if (wr_next) begin
                mem_a_wr_addr <= locked_dest_addr + pair_offset;
                mem_b_wr_addr <= locked_dest_addr + pair_offset + 1'b1;
                pair_cnt      <= pair_cnt + 1'b1;
            end else begin
                mem_a_wr_addr <= '0;
                mem_b_wr_addr <= '0;
            end
            // A new run may start while the previous one drains its last write
            if (start) begin
                locked_dest_addr <= dest_base_addr;
                pair_cnt         <= '0;
            end
        end
    end

endmodule

/* sigdecode_z_top.sv */
/*
 * Top level of the ML-DSA signature z decoder.
 * Connects the read sequencer, the write sequencer and eight decode units,
 * four on each memory port. Pulse sigdecode_z_enable to run one full z.
 */

`timescale 1ns/1ps

module sigdecode_z_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     sigdecode_z_enable,
    input  mldsa_z_pkg::mem_addr_t   sigmem_src_base_addr,
    input  mldsa_z_pkg::mem_addr_t   dest_base_addr,

    // Signature memory read side
    output logic                     sig_a_rd_en,
    output logic                     sig_b_rd_en,
    output mldsa_z_pkg::mem_addr_t   sig_a_rd_addr,
    output mldsa_z_pkg::mem_addr_t   sig_b_rd_addr,
    input  mldsa_z_pkg::z_enc_word_t sig_a_rd_data,
    input  mldsa_z_pkg::z_enc_word_t sig_b_rd_data,

    // Destination memory write side
    output logic                     mem_a_wr_en,
    output logic                     mem_b_wr_en,
    output mldsa_z_pkg::mem_addr_t   mem_a_wr_addr,
    output mldsa_z_pkg::mem_addr_t   mem_b_wr_addr,
    output mldsa_z_pkg::coef_word_t  mem_a_wr_data,
    output mldsa_z_pkg::coef_word_t  mem_b_wr_data,

    output logic                     sigdecode_z_done
);

    logic start;
    logic rd_issue;

    sigdecode_z_rd_ctrl i_rd_ctrl (
        .clk                  (clk),
        .reset_n              (reset_n),
        .zeroize              (zeroize),
        .sigdecode_z_enable   (sigdecode_z_enable),
        .sigmem_src_base_addr (sigmem_src_base_addr),
        .sig_a_rd_en          (sig_a_rd_en),
        .sig_b_rd_en          (sig_b_rd_en),
        .sig_a_rd_addr        (sig_a_rd_addr),
        .sig_b_rd_addr        (sig_b_rd_addr),
        .start                (start),
        .rd_issue             (rd_issue)
    );

    sigdecode_z_wr_ctrl i_wr_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .start            (start),
        .rd_issue         (rd_issue),
        .dest_base_addr   (dest_base_addr),
        .mem_a_wr_en      (mem_a_wr_en),
        .mem_b_wr_en      (mem_b_wr_en),
        .mem_a_wr_addr    (mem_a_wr_addr),
        .mem_b_wr_addr    (mem_b_wr_addr),
        .sigdecode_z_done (sigdecode_z_done)
    );

    // Coefficient i of each word sits at bit i times its width
    for (genvar i = 0; i < 4; i++) begin : g_dec
        sigdecode_z_unit i_unit_a (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .enc     (sig_a_rd_data[i*mldsa_z_pkg::Z_ENC_WIDTH +: mldsa_z_pkg::Z_ENC_WIDTH]),
            .coef    (mem_a_wr_data[i*mldsa_z_pkg::COEF_WIDTH +: mldsa_z_pkg::COEF_WIDTH])
        );

        sigdecode_z_unit i_unit_b (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .enc     (sig_b_rd_data[i*mldsa_z_pkg::Z_ENC_WIDTH +: mldsa_z_pkg::Z_ENC_WIDTH]),
            .coef    (mem_b_wr_data[i*mldsa_z_pkg::COEF_WIDTH +: mldsa_z_pkg::COEF_WIDTH])
        );
    end

endmodule

/* sigdecode_z_tb.sv */
/*
 * Self-checking testbench for the z decoder top level.
 * Reads run records and corner words from the trace file, models the
 * signature memory and checks every strobe, address and written word.
 */

`timescale 1ns/1ps

module sigdecode_z_tb;

    localparam int RUN_CYCLES = 228;
    localparam int MEM_WORDS  = 2 ** mldsa_z_pkg::MEM_ADDR_WIDTH;
    localparam int NO_ZEROIZE = 32'h7fff_ffff;

    logic                     clk;
    logic                     reset_n;
    logic                     zeroize;
    logic                     sigdecode_z_enable;
    mldsa_z_pkg::mem_addr_t   sigmem_src_base_addr;
    mldsa_z_pkg::mem_addr_t   dest_base_addr;
    logic                     sig_a_rd_en;
    logic                     sig_b_rd_en;
    mldsa_z_pkg::mem_addr_t   sig_a_rd_addr;
    mldsa_z_pkg::mem_addr_t   sig_b_rd_addr;
    mldsa_z_pkg::z_enc_word_t sig_a_rd_data;
    mldsa_z_pkg::z_enc_word_t sig_b_rd_data;
    logic                     mem_a_wr_en;
    logic                     mem_b_wr_en;
    mldsa_z_pkg::mem_addr_t   mem_a_wr_addr;
    mldsa_z_pkg::mem_addr_t   mem_b_wr_addr;
    mldsa_z_pkg::coef_word_t  mem_a_wr_data;
    mldsa_z_pkg::coef_word_t  mem_b_wr_data;
    logic                     sigdecode_z_done;

    mldsa_z_pkg::z_enc_word_t sig_mem [MEM_WORDS];
    mldsa_z_pkg::coef_word_t  exp_mem [MEM_WORDS];
    mldsa_z_pkg::coef_word_t  wr_data [MEM_WORDS];
    int                       wr_count [MEM_WORDS];

    int run_src [16];
    int run_dest [16];
    int run_zero [16];
    int n_runs;
    int n_corner;
    int errors;
    int cyc;
    int limit;

    // Current run as seen by the monitor
    int  cur_e;
    int  cur_src;
    int  cur_dest;
    int  cur_zc;
    logic done_seen;

    sigdecode_z_top i_sigdecode_z_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // Decodes x as gamma1 minus x and adds q when that is negative
    function automatic mldsa_z_pkg::coef_t ref_decode(input mldsa_z_pkg::z_enc_t x);
        int d;
        d = int'(mldsa_z_pkg::Z_GAMMA1) - int'(x);
        if (d < 0) begin
            d = d + int'(mldsa_z_pkg::MLDSA_Q);
        end
        return mldsa_z_pkg::coef_t'(d);
    endfunction

    function automatic mldsa_z_pkg::coef_word_t ref_word(input mldsa_z_pkg::z_enc_word_t w);
        mldsa_z_pkg::coef_word_t r;
        for (int i = 0; i < 4; i++) begin
            r[i*24 +: 24] = ref_decode(w[i*20 +: 20]);
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic load_trace();
        int fd;
        int rc;
        logic [8*256-1:0] line;
        logic [8*8-1:0]   kw;
        logic [19:0]      e [4];
        int               x [4];
        mldsa_z_pkg::z_enc_word_t w;
        mldsa_z_pkg::coef_word_t  v;
        fd = $fopen("sigdecode_z_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file sigdecode_z_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                kw   = '0;
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%s", kw);
                if (rc == 1 && kw == "run") begin
                    rc = $sscanf(line, "%s %h %h %d", kw, run_src[n_runs], run_dest[n_runs],
                                 run_zero[n_runs]);
                    n_runs++;
                end else if (rc == 1 && kw == "corner") begin
                    rc = $sscanf(line, "%s %h %h %h %h %d %d %d %d", kw, e[0], e[1], e[2],
                                 e[3], x[0], x[1], x[2], x[3]);
                    for (int i = 0; i < 4; i++) begin
                        w[i*20 +: 20] = e[i];
                        v[i*24 +: 24] = x[i];
                    end
                    check_value("reference decode of corner word", ref_word(w), v);
                    sig_mem[n_corner] = w;
                    exp_mem[n_corner] = v;
                    n_corner++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================
    // Signature memory model and monitor
    // ========================================

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (sig_a_rd_en) begin
            sig_a_rd_data <= sig_mem[sig_a_rd_addr];
        end
        if (sig_b_rd_en) begin
            sig_b_rd_data <= sig_mem[sig_b_rd_addr];
        end
        if (cyc > limit) begin
            $display("Timeout: the simulation ran past %0d cycles without finishing", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin : monitor
        logic exp_rd;
        logic exp_wr;
        logic exp_done;
        int   kr;
        int   kw;
        kr = cyc - cur_e - 1;
        kw = cyc - cur_e - 3;
        exp_rd   = (kr >= 0) && (kr < 224) && (cyc < cur_zc);
        exp_wr   = (kw >= 0) && (kw < 224) && (cyc < cur_zc);
        exp_done = (cyc == cur_e + RUN_CYCLES - 1) && (cyc < cur_zc);
        check_value("port a read strobe", sig_a_rd_en, exp_rd);
        check_value("port b read strobe", sig_b_rd_en, exp_rd);
        check_value("port a read address", sig_a_rd_addr, exp_rd ? cur_src + 2 * kr : 0);
        check_value("port b read address", sig_b_rd_addr, exp_rd ? cur_src + 2 * kr + 1 : 0);
        check_value("port a write strobe", mem_a_wr_en, exp_wr);
        check_value("port b write strobe", mem_b_wr_en, exp_wr);
        check_value("port a write address", mem_a_wr_addr, exp_wr ? cur_dest + 2 * kw : 0);
        check_value("port b write address", mem_b_wr_addr, exp_wr ? cur_dest + 2 * kw + 1 : 0);
        check_value("done", sigdecode_z_done, exp_done);
        if (sigdecode_z_done) begin
            done_seen = 1'b1;
        end
        if (mem_a_wr_en && exp_wr) begin
            check_value("port a write data", mem_a_wr_data,
                        exp_mem[mldsa_z_pkg::mem_addr_t'(cur_src + 2 * kw)]);
            wr_count[mem_a_wr_addr] = wr_count[mem_a_wr_addr] + 1;
            wr_data[mem_a_wr_addr]  = mem_a_wr_data;
        end
        if (mem_b_wr_en && exp_wr) begin
            check_value("port b write data", mem_b_wr_data,
                        exp_mem[mldsa_z_pkg::mem_addr_t'(cur_src + 2 * kw + 1)]);
            wr_count[mem_b_wr_addr] = wr_count[mem_b_wr_addr] + 1;
            wr_data[mem_b_wr_addr]  = mem_b_wr_data;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic do_run(input int r);
        int dst;
        for (int a = 0; a < MEM_WORDS; a++) begin
            wr_data[a]  = 'x;
            wr_count[a] = 0;
        end
        done_seen = 1'b0;
        @(posedge clk);
        sigdecode_z_enable   <= 1'b1;
        sigmem_src_base_addr <= run_src[r];
        dest_base_addr       <= run_dest[r];
        cur_src  = run_src[r];
        cur_dest = run_dest[r];
        cur_zc   = (run_zero[r] != 0) ? cyc + 2 + run_zero[r] : NO_ZEROIZE;
        cur_e    = cyc + 2;
        @(posedge clk);
        sigdecode_z_enable <= 1'b0;
        // A second request during the run must be ignored
        while (cyc != cur_e + 47) @(posedge clk);
        sigdecode_z_enable   <= 1'b1;
        sigmem_src_base_addr <= run_src[r] + 16;
        dest_base_addr       <= run_dest[r] + 16;
        @(posedge clk);
        sigdecode_z_enable <= 1'b0;
        if (run_zero[r] != 0) begin
            while (cyc != cur_zc - 2) @(posedge clk);
            zeroize <= 1'b1;
            @(posedge clk);
            zeroize <= 1'b0;
            while (cyc < cur_e + RUN_CYCLES + 8) @(posedge clk);
        end else begin
            while (!done_seen) @(posedge clk);
            repeat (4) @(posedge clk);
            for (int m = 0; m < mldsa_z_pkg::Z_NUM_WORDS; m++) begin
                dst = mldsa_z_pkg::mem_addr_t'(cur_dest + m);
                check_value("write count", wr_count[dst], 1);
                check_value("stored word", wr_data[dst],
                            exp_mem[mldsa_z_pkg::mem_addr_t'(cur_src + m)]);
            end
        end
    endtask

    initial begin : stimulus
        logic [15:0] lfsr;
        reset_n              = 1'b0;
        zeroize              = 1'b0;
        sigdecode_z_enable   = 1'b0;
        sigmem_src_base_addr = '0;
        dest_base_addr       = '0;
        sig_a_rd_data        = '0;
        sig_b_rd_data        = '0;
        cyc      = 0;
        errors   = 0;
        n_runs   = 0;
        n_corner = 0;
        limit    = NO_ZEROIZE;
        cur_e    = -1000;
        cur_zc   = NO_ZEROIZE;
        load_trace();
        lfsr = 16'd26458;
        for (int a = n_corner; a < MEM_WORDS; a++) begin
            for (int b = 0; b < 80; b++) begin
                sig_mem[a][b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            exp_mem[a] = ref_word(sig_mem[a]);
        end
        limit = n_runs * (RUN_CYCLES + 20) + 100;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int r = 0; r < n_runs; r++) begin
            do_run(r);
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sigdecode_z_trace.txt */
# run <src base hex> <dest base hex> <zeroize cycle after enable, 0 for none>
# corner <four encoded values hex> <four expected decoded values decimal>
corner 00000 80000 80001 fffff 524288 0 8380416 7856130
corner 00001 7ffff 40000 c0000 524287 1 262144 8118273
corner ffffe 80002 00010 a5a5a 7856131 8380415 524272 8226215
run 0000 1000 0
run 0123 2000 0
run 0040 3000 100
run 7e00 0400 0

/* vlog.f */
mldsa_z_pkg.sv
sigdecode_z_rd_ctrl.sv
sigdecode_z_unit.sv
sigdecode_z_wr_ctrl.sv
sigdecode_z_top.sv
sigdecode_z_tb.sv

/* Bender.yml */
package:
  name: sigdecode_z

sources:
  - mldsa_z_pkg.sv
  - sigdecode_z_rd_ctrl.sv
  - sigdecode_z_unit.sv
  - sigdecode_z_wr_ctrl.sv
  - sigdecode_z_top.sv
  - target: simulation
    files:
      - sigdecode_z_tb.sv
